//--- verilog.f
rtl/pitaya_pkg.sv
rtl/sys_bus_if.sv
rtl/sys_bus_decoder.sv
rtl/hk_regs.sv
rtl/adc_frontend.sv
rtl/prop_feedback.sv
rtl/dac_backend.sv
rtl/pitaya_core.sv
testbench/tb_pitaya_core.sv

//--- Makefile
# Verilator build and run of the fast analog core testbench

VERILATOR ?= verilator
TOP       ?= tb_pitaya_core
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/tb_pitaya_core.sv
// testbench for the fast analog core, random bus and ADC stimulus against a cycle model
`default_nettype none

module tb_pitaya_core;

  localparam int clk_period   = 20;
  localparam int half         = 2 ** (pitaya_pkg::adc_w - 1);  // 8192
  localparam int zero_code    = half - 1;                      // DAC code for 0
  localparam int max_ack_wait = 4;

  // test lengths, in rounds
  localparam int n_reg  = 48;
  localparam int n_unm  = 12;
  localparam int n_lvl  = 12;
  localparam int n_fb   = 12;
  localparam int n_loop = 12;
  // one access is 2 cycles, plus settle time per round
  localparam int planned_cycles = 4 + n_reg * 4 + n_unm * 4 + n_lvl * 8 + n_fb * 40
                                  + n_loop * 24 + 200;
  localparam int timeout = planned_cycles * clk_period + 100 * clk_period;

  typedef logic [pitaya_pkg::bus_w-1:0]    word_t;
  typedef logic [pitaya_pkg::adc_w-1:0]    code_t;
  typedef logic [pitaya_pkg::region_w-1:0] region_t;

  localparam region_t mapped_regions [3] =
    '{pitaya_pkg::reg_hk, pitaya_pkg::reg_gen, pitaya_pkg::reg_pid};
  localparam region_t unmapped_regions [5] = '{3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

  logic                         adc_clk;
  logic                         arst_n;
  code_t                        adc_dat_a;
  code_t                        adc_dat_b;
  word_t                        sys_addr;
  word_t                        sys_wdata;
  logic                         sys_wen;
  logic                         sys_ren;
  word_t                        sys_rdata;
  logic                         sys_ack;
  logic                         sys_err;
  code_t                        dac_dat_a;
  code_t                        dac_dat_b;
  logic [pitaya_pkg::led_w-1:0] led;

  // model state
  int                           m_adc [2];  // pin register, raw code
  int                           m_pid [2];  // P term register
  int                           m_dac [2];  // DAC pin register, raw code
  int                           m_lvl [2];
  int                           m_kp  [2];
  logic                         m_loop;
  logic [pitaya_pkg::led_w-1:0] m_led;
  logic                         monitor_on;
  logic                         sat_hi_seen;  // P term hit +limit
  logic                         sat_lo_seen;

  pitaya_core pitaya_core_inst (
    .adc_clk (adc_clk), .arst_n_i (arst_n),
    .adc_dat_a_i (adc_dat_a), .adc_dat_b_i (adc_dat_b),
    .sys_addr_i (sys_addr), .sys_wdata_i (sys_wdata),
    .sys_wen_i (sys_wen), .sys_ren_i (sys_ren),
    .sys_rdata_o (sys_rdata), .sys_ack_o (sys_ack), .sys_err_o (sys_err),
    .dac_dat_a_o (dac_dat_a), .dac_dat_b_o (dac_dat_b), .led_o (led)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #(clk_period / 2) adc_clk = ~adc_clk;
  end

  ////////////////////////////////////////
  // reporting and compares
  ////////////////////////////////////////
  task automatic stop_on_failure(string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(string what, word_t got, word_t exp, logic got_err, logic exp_err);
    if (got !== exp || got_err !== exp_err)
      stop_on_failure($sformatf("Error: time %0t: %s got %h err %b, expected %h err %b",
                                $time, what, got, got_err, exp, exp_err));
  endtask

  task automatic check_sample(string what, pitaya_pkg::sample_t got, pitaya_pkg::sample_t exp);
    if (got !== exp)
      stop_on_failure($sformatf("Error: time %0t: %s got %0d, expected %0d",
                                $time, what, got, exp));
  endtask

  task automatic check_dac(string what, code_t got, code_t exp);
    if (got !== exp)
      stop_on_failure($sformatf("Error: time %0t: %s got code %h, expected %h",
                                $time, what, got, exp));
  endtask

  ////////////////////////////////////////
  // model arithmetic
  ////////////////////////////////////////
  function automatic int sat_sample(int x);
    if (x > half - 1)
      return half - 1;
    if (x < -half)
      return -half;
    return x;
  endfunction

  // negative slope offset binary, code falls as value rises
  function automatic int code_to_sample(int code);
    return zero_code - code;
  endfunction

  function automatic int sample_to_code(int s);
    return zero_code - s;
  endfunction

  function automatic int field_value(word_t data);
    int v;
    v = int'(data[pitaya_pkg::adc_w-1:0]);
    if (v >= half)
      v = v - 2 * half;  // sign of the 14 bit field
    return v;
  endfunction

  function automatic logic expected_err(word_t addr);
    logic [19:0] off;
    off = addr[19:0];
    if (addr[22:20] == pitaya_pkg::reg_hk)
      return !(off inside {pitaya_pkg::off_ctrl, pitaya_pkg::off_led});
    if (addr[22:20] inside {pitaya_pkg::reg_gen, pitaya_pkg::reg_pid})
      return !(off inside {pitaya_pkg::off_ch_a, pitaya_pkg::off_ch_b});
    return 1'b0;  // tie off never errs
  endfunction

  function automatic word_t expected_rdata(word_t addr);
    int ch;
    ch = (addr[19:0] == pitaya_pkg::off_ch_b) ? 1 : 0;
    if (expected_err(addr))
      return '0;
    case (addr[22:20])
      pitaya_pkg::reg_hk:  return (addr[19:0] == pitaya_pkg::off_ctrl) ? word_t'(m_loop)
                                                                        : word_t'(m_led);
      pitaya_pkg::reg_gen: return word_t'(m_lvl[ch]);  // sign extended
      pitaya_pkg::reg_pid: return word_t'(m_kp[ch]);
      default:             return '0;
    endcase
  endfunction

  task automatic model_write(word_t addr, word_t data);
    logic [19:0] off;
    off = addr[19:0];
    case (addr[22:20])
      pitaya_pkg::reg_hk:
      begin
        if (off == pitaya_pkg::off_ctrl)
          m_loop = data[0];
        else if (off == pitaya_pkg::off_led)
          m_led = data[pitaya_pkg::led_w-1:0];
      end
      pitaya_pkg::reg_gen:
      begin
        if (off == pitaya_pkg::off_ch_a)
          m_lvl[0] = field_value(data);
        else if (off == pitaya_pkg::off_ch_b)
          m_lvl[1] = field_value(data);
      end
      pitaya_pkg::reg_pid:
      begin
        if (off == pitaya_pkg::off_ch_a)
          m_kp[0] = field_value(data);
        else if (off == pitaya_pkg::off_ch_b)
          m_kp[1] = field_value(data);
      end
      default: ;  // unmapped, nothing stored
    endcase
  endtask

  // one step per clock, all three pipeline stages
  always @(posedge adc_clk or negedge arst_n)
  begin : model_step
    int sum;
    int din;
    int prod;
    if (!arst_n)
    begin
      for (int ch = 0; ch < 2; ch++)
      begin
        m_adc[ch] = 0;
        m_pid[ch] = 0;
        m_dac[ch] = zero_code;
        m_lvl[ch] = 0;
        m_kp[ch]  = 0;
      end
      m_loop = 1'b0;
      m_led  = '0;
    end
    else
    begin
      for (int ch = 0; ch < 2; ch++)
      begin
        sum  = sat_sample(m_lvl[ch] + m_pid[ch]);
        din  = m_loop ? sum : code_to_sample(m_adc[ch]);  // loopback or pins
        prod = (din * m_kp[ch]) >>> pitaya_pkg::kp_shift;
        if (prod >= half)
          sat_hi_seen = 1'b1;
        if (prod < -half)
          sat_lo_seen = 1'b1;
        m_pid[ch] = sat_sample(prod);
        m_dac[ch] = sample_to_code(sum);
      end
      m_adc[0] = int'(adc_dat_a);
      m_adc[1] = int'(adc_dat_b);
      if (sys_wen)
        model_write(sys_addr, sys_wdata);
    end
  end

  // pins and LEDs every cycle, sampled away from the rising edge
  always @(negedge adc_clk)
  begin
    if (arst_n === 1'b1 && monitor_on === 1'b1)
    begin
      check_dac("dac_dat_a_o", dac_dat_a, code_t'(m_dac[0]));
      check_dac("dac_dat_b_o", dac_dat_b, code_t'(m_dac[1]));
      check_word("led_o", word_t'(led), word_t'(m_led), 1'b0, 1'b0);
    end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////
  task automatic wait_cycles(int n);
    repeat (n) @(negedge adc_clk);
  endtask

  task automatic drive_adc();
    forever
    begin
      @(negedge adc_clk);
      adc_dat_a = code_t'($urandom);
      adc_dat_b = code_t'($urandom);
    end
  endtask

  function automatic word_t make_addr(region_t region, logic [19:0] offset);
    word_t a;
    a        = $urandom;  // upper bits are don't care
    a[22:20] = region;
    a[19:0]  = offset;
    return a;
  endfunction

  // 0 ctrl, 1 led, 2/3 level a/b, 4/5 gain a/b, else a bad offset
  function automatic word_t mapped_addr(int k);
    case (k)
      0:       return make_addr(pitaya_pkg::reg_hk, pitaya_pkg::off_ctrl);
      1:       return make_addr(pitaya_pkg::reg_hk, pitaya_pkg::off_led);
      2:       return make_addr(pitaya_pkg::reg_gen, pitaya_pkg::off_ch_a);
      3:       return make_addr(pitaya_pkg::reg_gen, pitaya_pkg::off_ch_b);
      4:       return make_addr(pitaya_pkg::reg_pid, pitaya_pkg::off_ch_a);
      5:       return make_addr(pitaya_pkg::reg_pid, pitaya_pkg::off_ch_b);
      default: return make_addr(mapped_regions[$urandom_range(2, 0)],
                                20'($urandom_range(1023, 2) * 4));
    endcase
  endfunction

  // strobe for one cycle, hold addr and data until ack
  task automatic bus_access(input logic write, input word_t addr, input word_t data,
                            output word_t rdata, output logic err);
    int   waited;
    logic unmapped;
    waited   = 0;
    unmapped = !(addr[22:20] inside {pitaya_pkg::reg_hk, pitaya_pkg::reg_gen,
                                     pitaya_pkg::reg_pid});
    @(negedge adc_clk);
    sys_addr  = addr;
    sys_wdata = data;
    sys_wen   = write;
    sys_ren   = !write;
    // unmapped regions ack in the strobe cycle, mapped ones a cycle later
    #(clk_period / 4);
    if (sys_ack !== unmapped)
      stop_on_failure($sformatf("bus access to %h acked in the wrong cycle", addr));
    @(negedge adc_clk);
    while (sys_ack !== 1'b1)
    begin
      sys_wen = 1'b0;
      sys_ren = 1'b0;
      waited++;
      if (waited > max_ack_wait)
        stop_on_failure($sformatf("bus access to %h got no ack", addr));
      @(negedge adc_clk);
    end
    if (waited != 0)
      stop_on_failure($sformatf("bus access to %h acked %0d cycles late", addr, waited));
    rdata   = sys_rdata;
    err     = sys_err;
    sys_wen = 1'b0;
    sys_ren = 1'b0;
  endtask

  task automatic write_reg(word_t addr, word_t data);
    word_t rd;
    logic  err;
    bus_access(1'b1, addr, data, rd, err);
    check_word($sformatf("write to %h", addr), '0, '0, err, expected_err(addr));
  endtask

  task automatic read_reg(word_t addr, output word_t rd);
    logic err;
    bus_access(1'b0, addr, '0, rd, err);
    check_word($sformatf("read of %h", addr), rd, expected_rdata(addr), err,
               expected_err(addr));
  endtask

  task automatic verify_regs();
    word_t rd;
    for (int k = 0; k < 6; k++)
      read_reg(mapped_addr(k), rd);
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial
  begin : stimulus
    word_t addr;
    word_t rd;
    int    k;
    void'($urandom(32'h5830));
    arst_n      = 1'b0;
    adc_dat_a   = '0;
    adc_dat_b   = '0;
    sys_addr    = '0;
    sys_wdata   = '0;
    sys_wen     = 1'b0;
    sys_ren     = 1'b0;
    monitor_on  = 1'b0;
    sat_hi_seen = 1'b0;
    sat_lo_seen = 1'b0;
    wait_cycles(4);
    arst_n = 1'b1;
    fork
      drive_adc();
    join_none
    monitor_on = 1'b1;

    // register access, including bad offsets
    repeat (n_reg)
    begin
      k    = $urandom_range(6, 0);
      addr = mapped_addr(k);
      write_reg(addr, $urandom);
      read_reg(addr, rd);
    end
    verify_regs();

    // unmapped regions read zero and store nothing
    repeat (n_unm)
    begin
      addr = make_addr(unmapped_regions[$urandom_range(4, 0)], 20'($urandom_range(3, 0) * 4));
      write_reg(addr, $urandom);
      read_reg(addr, rd);
    end
    verify_regs();

    // level path, gains at zero
    write_reg(mapped_addr(0), '0);
    write_reg(mapped_addr(4), '0);
    write_reg(mapped_addr(5), '0);
    repeat (n_lvl)
    begin
      write_reg(mapped_addr(2), $urandom);
      write_reg(mapped_addr(3), $urandom);
      wait_cycles(4);
      check_sample("level a", pitaya_pkg::sample_t'(code_to_sample(int'(dac_dat_a))),
                   pitaya_pkg::sample_t'(m_lvl[0]));
      check_sample("level b", pitaya_pkg::sample_t'(code_to_sample(int'(dac_dat_b))),
                   pitaya_pkg::sample_t'(m_lvl[1]));
    end

    // feedback from the ADC pins
    repeat (n_fb)
    begin
      write_reg(mapped_addr(4), $urandom);
      write_reg(mapped_addr(5), $urandom);
      write_reg(mapped_addr(2), $urandom);
      write_reg(mapped_addr(3), $urandom);
      wait_cycles(32);
    end

    // closed loop through the DAC sum, then back to the pins
    write_reg(mapped_addr(0), 32'h1);
    repeat (n_loop)
    begin
      write_reg(mapped_addr(4), $urandom);
      write_reg(mapped_addr(5), $urandom);
      write_reg(mapped_addr(2), $urandom);
      write_reg(mapped_addr(3), $urandom);
      wait_cycles(16);
    end
    write_reg(mapped_addr(0), '0);
    wait_cycles(16);

    // second reset mid run
    @(negedge adc_clk);
    arst_n = 1'b0;
    wait_cycles(4);
    check_word("led_o in reset", word_t'(led), '0, 1'b0, 1'b0);
    check_dac("dac a in reset", dac_dat_a, code_t'(sample_to_code(0)));
    check_dac("dac b in reset", dac_dat_b, code_t'(sample_to_code(0)));
    arst_n = 1'b1;
    verify_regs();
    wait_cycles(8);

    if (sat_hi_seen && sat_lo_seen)
    begin
      $display("RESULT: PASS");
      $finish;
    end
    else
      stop_on_failure("the feedback never reached both saturation limits");
  end

  initial
  begin : watchdog
    #(timeout);
    stop_on_failure("the run took longer than its planned length");
  end

endmodule

`default_nettype wire

//--- rtl/pitaya_core.sv
// fast analog core top level, bus decoder and sample path wiring
`default_nettype none

module pitaya_core (
  input  logic                         adc_clk,
  input  logic                         arst_n_i,
  input  logic [pitaya_pkg::adc_w-1:0] adc_dat_a_i,   // CH 1, neg slope
  input  logic [pitaya_pkg::adc_w-1:0] adc_dat_b_i,   // CH 2
  input  logic [pitaya_pkg::bus_w-1:0] sys_addr_i,
  input  logic [pitaya_pkg::bus_w-1:0] sys_wdata_i,
  input  logic                         sys_wen_i,
  input  logic                         sys_ren_i,
  output logic [pitaya_pkg::bus_w-1:0] sys_rdata_o,
  output logic                         sys_ack_o,
  output logic                         sys_err_o,
  output logic [pitaya_pkg::adc_w-1:0] dac_dat_a_o,   // CH 1, separate port
  output logic [pitaya_pkg::adc_w-1:0] dac_dat_b_o,
  output logic [pitaya_pkg::led_w-1:0] led_o
);

  pitaya_pkg::sample_t adc_a;   // converted or looped back
  pitaya_pkg::sample_t adc_b;
  pitaya_pkg::sample_t pid_a;   // P term
  pitaya_pkg::sample_t pid_b;
  pitaya_pkg::sample_t loop_a;  // saturated DAC sum
  pitaya_pkg::sample_t loop_b;
  logic                digital_loop;

  sys_bus_if hk_bus ();
  sys_bus_if gen_bus ();
  sys_bus_if pid_bus ();

  ////////////////////////////////////////
  // bus side
  ////////////////////////////////////////
  sys_bus_decoder sys_bus_decoder_inst (
    .adc_clk (adc_clk), .arst_n_i (arst_n_i),
    .sys_addr_i (sys_addr_i), .sys_wdata_i (sys_wdata_i),
    .sys_wen_i (sys_wen_i), .sys_ren_i (sys_ren_i),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o (sys_ack_o), .sys_err_o (sys_err_o),
    .hk_bus (hk_bus.master), .gen_bus (gen_bus.master), .pid_bus (pid_bus.master)
  );

  hk_regs hk_regs_inst (
    .adc_clk (adc_clk), .arst_n_i (arst_n_i), .bus (hk_bus.slave),
    .led_o (led_o), .digital_loop_o (digital_loop)
  );

  ////////////////////////////////////////
  // sample path, ADC to DAC in 3 cycles
  ////////////////////////////////////////
  adc_frontend adc_frontend_inst (
    .adc_clk (adc_clk), .arst_n_i (arst_n_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .digital_loop_i (digital_loop), .loop_a_i (loop_a), .loop_b_i (loop_b),
    .adc_a_o (adc_a), .adc_b_o (adc_b)
  );

  prop_feedback prop_feedback_inst (
    .adc_clk (adc_clk), .arst_n_i (arst_n_i), .bus (pid_bus.slave),
    .dat_a_i (adc_a), .dat_b_i (adc_b), .dat_a_o (pid_a), .dat_b_o (pid_b)
  );

  dac_backend dac_backend_inst (
    .adc_clk (adc_clk), .arst_n_i (arst_n_i), .bus (gen_bus.slave),
    .fb_a_i (pid_a), .fb_b_i (pid_b), .loop_a_o (loop_a), .loop_b_o (loop_b),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

`default_nettype wire

//--- rtl/dac_backend.sv
// per channel DC level, sum with feedback, saturation, DAC output register
`default_nettype none

module dac_backend (
  input  logic                         adc_clk,
  input  logic                         arst_n_i,
  sys_bus_if.slave                     bus,
  input  pitaya_pkg::sample_t          fb_a_i,
  input  pitaya_pkg::sample_t          fb_b_i,
  output pitaya_pkg::sample_t          loop_a_o,
  output pitaya_pkg::sample_t          loop_b_o,
  output logic [pitaya_pkg::adc_w-1:0] dac_dat_a_o,
  output logic [pitaya_pkg::adc_w-1:0] dac_dat_b_o
);

  localparam int w  = pitaya_pkg::adc_w;
  localparam int sw = pitaya_pkg::sum_w;

  pitaya_pkg::sample_t                 lvl     [2];  // DC level per channel
  logic signed [pitaya_pkg::bus_w-1:0] lvl_ext [2];
  pitaya_pkg::sample_t                 fb      [2];
  pitaya_pkg::sample_t                 sat     [2];  // also the loopback sample
  logic [w-1:0]                        dac_q   [2];  // offset binary, neg slope
  logic                                is_a;
  logic                                is_b;

  assign fb[0]       = fb_a_i;
  assign fb[1]       = fb_b_i;
  assign loop_a_o    = sat[0];
  assign loop_b_o    = sat[1];
  assign dac_dat_a_o = dac_q[0];
  assign dac_dat_b_o = dac_q[1];
  assign is_a        = bus.addr.fields.offset == pitaya_pkg::off_ch_a;
  assign is_b        = bus.addr.fields.offset == pitaya_pkg::off_ch_b;

  for (genvar ch = 0; ch < 2; ch++)
  begin : g_ch
    logic signed [sw-1:0] sum;
    assign lvl_ext[ch] = lvl[ch];
    assign sum         = lvl[ch] + fb[ch];
    // top two bits differ on overflow
    assign sat[ch] = (^sum[sw-1:sw-2]) ? {sum[sw-1], {(w-1){~sum[sw-1]}}} : sum[w-1:0];

    assert property (@(posedge adc_clk) disable iff (!arst_n_i)
      (sum >= -(2**(w-1)) && sum < 2**(w-1)) |-> sat[ch] == sum[w-1:0]);
  end

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      lvl       <= '{default: '0};
      dac_q     <= '{default: {1'b0, {(w-1){1'b1}}}};  // code for zero
      bus.ack   <= 1'b0;
      bus.err   <= 1'b0;
      bus.rdata <= '0;
    end
    else
    begin
      dac_q[0] <= {sat[0][w-1], ~sat[0][w-2:0]};
      dac_q[1] <= {sat[1][w-1], ~sat[1][w-2:0]};
      bus.ack  <= bus.wen | bus.ren;
      bus.err  <= (bus.wen | bus.ren) & ~(is_a | is_b);
      if (bus.wen && is_a)
        lvl[0] <= bus.wdata[w-1:0];
      if (bus.wen && is_b)
        lvl[1] <= bus.wdata[w-1:0];
      if (bus.ren)
        bus.rdata <= is_a ? lvl_ext[0] : (is_b ? lvl_ext[1] : '0);
    end
  end

endmodule

`default_nettype wire

//--- rtl/prop_feedback.sv
// per channel gain registers and registered proportional feedback
`default_nettype none

module prop_feedback (
  input  logic                adc_clk,
  input  logic                arst_n_i,
  sys_bus_if.slave            bus,
  input  pitaya_pkg::sample_t dat_a_i,
  input  pitaya_pkg::sample_t dat_b_i,
  output pitaya_pkg::sample_t dat_a_o,
  output pitaya_pkg::sample_t dat_b_o
);

  localparam int w = pitaya_pkg::adc_w;

  pitaya_pkg::sample_t                 kp     [2];  // signed gain per channel
  logic signed [pitaya_pkg::bus_w-1:0] kp_ext [2];  // sign extended for reads
  pitaya_pkg::sample_t                 din    [2];
  pitaya_pkg::sample_t                 sat    [2];
  pitaya_pkg::sample_t                 dout   [2];
  logic                                is_a;
  logic                                is_b;

  assign din[0]  = dat_a_i;
  assign din[1]  = dat_b_i;
  assign dat_a_o = dout[0];
  assign dat_b_o = dout[1];
  assign is_a    = bus.addr.fields.offset == pitaya_pkg::off_ch_a;
  assign is_b    = bus.addr.fields.offset == pitaya_pkg::off_ch_b;

  ////////////////////////////////////////
  // P term per channel
  ////////////////////////////////////////
  for (genvar ch = 0; ch < 2; ch++)
  begin : g_ch
    logic signed [2*w-1:0] prod;     // full product
    logic signed [2*w-1:0] prod_sh;  // after arithmetic shift
    logic                  in_rng;

    assign kp_ext[ch] = kp[ch];
    assign prod       = din[ch] * kp[ch];
    assign prod_sh    = prod >>> pitaya_pkg::kp_shift;
    // fits when all bits above the sample msb copy it
    assign in_rng     = &prod_sh[2*w-1:w-1] | ~|prod_sh[2*w-1:w-1];
    assign sat[ch]    = in_rng ? prod_sh[w-1:0] : {prod_sh[2*w-1], {(w-1){~prod_sh[2*w-1]}}};

    // same gain, same input gives same output one cycle on
    assert property (@(posedge adc_clk) disable iff (!arst_n_i)
      $past(arst_n_i) && $stable(din[ch]) && $stable(kp[ch]) |=> $stable(dout[ch]));
  end

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      kp        <= '{default: '0};
      dout      <= '{default: '0};
      bus.ack   <= 1'b0;
      bus.err   <= 1'b0;
      bus.rdata <= '0;
    end
    else
    begin
      dout    <= sat;  // 1 cycle sample to output
      bus.ack <= bus.wen | bus.ren;
      bus.err <= (bus.wen | bus.ren) & ~(is_a | is_b);
      if (bus.wen && is_a)
        kp[0] <= bus.wdata[w-1:0];
      if (bus.wen && is_b)
        kp[1] <= bus.wdata[w-1:0];
      if (bus.ren)
        bus.rdata <= is_a ? kp_ext[0] : (is_b ? kp_ext[1] : '0);
    end
  end

endmodule

`default_nettype wire

//--- rtl/adc_frontend.sv
// ADC input registers, negative slope conversion, loopback select
`default_nettype none

module adc_frontend (
  input  logic                         adc_clk,
  input  logic                         arst_n_i,
  input  logic [pitaya_pkg::adc_w-1:0] adc_dat_a_i,
  input  logic [pitaya_pkg::adc_w-1:0] adc_dat_b_i,
  input  logic                         digital_loop_i,
  input  pitaya_pkg::sample_t          loop_a_i,
  input  pitaya_pkg::sample_t          loop_b_i,
  output pitaya_pkg::sample_t          adc_a_o,
  output pitaya_pkg::sample_t          adc_b_o
);

  localparam int w = pitaya_pkg::adc_w;

  logic [w-1:0] adc_dat_a;  // pin register, ideally in the IO block
  logic [w-1:0] adc_dat_b;

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      adc_dat_a <= '0;
      adc_dat_b <= '0;
    end
    else
    begin
      adc_dat_a <= adc_dat_a_i;
      adc_dat_b <= adc_dat_b_i;
    end
  end

  // keep msb, invert the rest, loopback bypasses the pins
  assign adc_a_o = digital_loop_i ? loop_a_i : {adc_dat_a[w-1], ~adc_dat_a[w-2:0]};
  assign adc_b_o = digital_loop_i ? loop_b_i : {adc_dat_b[w-1], ~adc_dat_b[w-2:0]};

endmodule

`default_nettype wire

//--- rtl/hk_regs.sv
// housekeeping registers, LED word and digital loopback control
`default_nettype none

module hk_regs (
  input  logic                         adc_clk,
  input  logic                         arst_n_i,
  sys_bus_if.slave                     bus,
  output logic [pitaya_pkg::led_w-1:0] led_o,
  output logic                         digital_loop_o
);

  logic [pitaya_pkg::led_w-1:0] led_q;
  logic                         loop_q;   // ctrl bit 0
  logic                         is_ctrl;
  logic                         is_led;
  logic                         access;   // any strobe this cycle

  assign is_ctrl = bus.addr.fields.offset == pitaya_pkg::off_ctrl;
  assign is_led  = bus.addr.fields.offset == pitaya_pkg::off_led;
  assign access  = bus.wen | bus.ren;

  ////////////////////////////////////////
  // register file and bus reply
  ////////////////////////////////////////
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      led_q     <= '0;  // LEDs off
      loop_q    <= 1'b0;
      bus.ack   <= 1'b0;
      bus.err   <= 1'b0;
      bus.rdata <= '0;
    end
    else
    begin
      bus.ack <= access;                          // one cycle late
      bus.err <= access & ~(is_ctrl | is_led);    // unknown offset
      if (bus.wen && is_ctrl)
        loop_q <= bus.wdata[0];
      if (bus.wen && is_led)
        led_q <= bus.wdata[pitaya_pkg::led_w-1:0];
      if (bus.ren)
      begin
        if (is_ctrl)
          bus.rdata <= {{(pitaya_pkg::bus_w-1){1'b0}}, loop_q};
        else if (is_led)
          bus.rdata <= {{(pitaya_pkg::bus_w-pitaya_pkg::led_w){1'b0}}, led_q};
        else
          bus.rdata <= '0;
      end
    end
  end

  assign led_o          = led_q;
  assign digital_loop_o = loop_q;

endmodule

`default_nettype wire

//--- rtl/sys_bus_decoder.sv
// system bus region decoder, strobe routing and reply multiplexer
`default_nettype none

module sys_bus_decoder (
  input  logic                         adc_clk,
  input  logic                         arst_n_i,
  input  pitaya_pkg::sys_addr_u        sys_addr_i,
  input  logic [pitaya_pkg::bus_w-1:0] sys_wdata_i,
  input  logic                         sys_wen_i,
  input  logic                         sys_ren_i,
  output logic [pitaya_pkg::bus_w-1:0] sys_rdata_o,
  output logic                         sys_ack_o,
  output logic                         sys_err_o,
  sys_bus_if.master                    hk_bus,
  sys_bus_if.master                    gen_bus,
  sys_bus_if.master                    pid_bus
);

  logic [pitaya_pkg::n_region-1:0] sys_cs;  // one hot region select

  assign sys_cs = {{(pitaya_pkg::n_region-1){1'b0}}, 1'b1} << sys_addr_i.fields.region;

  ////////////////////////////////////////
  // request fan out
  ////////////////////////////////////////
  assign hk_bus.addr   = sys_addr_i;
  assign hk_bus.wdata  = sys_wdata_i;
  assign hk_bus.wen    = sys_wen_i & sys_cs[pitaya_pkg::reg_hk];
  assign hk_bus.ren    = sys_ren_i & sys_cs[pitaya_pkg::reg_hk];
  assign gen_bus.addr  = sys_addr_i;
  assign gen_bus.wdata = sys_wdata_i;
  assign gen_bus.wen   = sys_wen_i & sys_cs[pitaya_pkg::reg_gen];
  assign gen_bus.ren   = sys_ren_i & sys_cs[pitaya_pkg::reg_gen];
  assign pid_bus.addr  = sys_addr_i;
  assign pid_bus.wdata = sys_wdata_i;
  assign pid_bus.wen   = sys_wen_i & sys_cs[pitaya_pkg::reg_pid];
  assign pid_bus.ren   = sys_ren_i & sys_cs[pitaya_pkg::reg_pid];

  // reply mux, unmapped regions answer at once with zero
  always_comb
  begin
    unique case (sys_addr_i.fields.region)
      pitaya_pkg::reg_hk:
      begin
        sys_rdata_o = hk_bus.rdata;
        sys_ack_o   = hk_bus.ack;
        sys_err_o   = hk_bus.err;
      end
      pitaya_pkg::reg_gen:
      begin
        sys_rdata_o = gen_bus.rdata;
        sys_ack_o   = gen_bus.ack;
        sys_err_o   = gen_bus.err;
      end
      pitaya_pkg::reg_pid:
      begin
        sys_rdata_o = pid_bus.rdata;
        sys_ack_o   = pid_bus.ack;
        sys_err_o   = pid_bus.err;
      end
      default:
      begin
        sys_rdata_o = '0;
        sys_ack_o   = sys_wen_i | sys_ren_i;  // tie off, same cycle
        sys_err_o   = 1'b0;
      end
    endcase
  end

  // master never reads and writes in one cycle
  assert property (@(posedge adc_clk) disable iff (!arst_n_i) !(sys_wen_i && sys_ren_i));

endmodule

`default_nettype wire

//--- rtl/sys_bus_if.sv
// system bus interface, request side and reply side modports
`default_nettype none

interface sys_bus_if;
  pitaya_pkg::sys_addr_u          addr;   // held until ack
  logic [pitaya_pkg::bus_w-1:0]   wdata;  // full word writes only
  logic                           wen;    // one cycle strobe
  logic                           ren;    // one cycle strobe
  logic [pitaya_pkg::bus_w-1:0]   rdata;  // valid with ack
  logic                           ack;
  logic                           err;    // unknown offset

  // decoder side
  modport master (output addr, wdata, wen, ren, input rdata, ack, err);
  // register block side
  modport slave (input addr, wdata, wen, ren, output rdata, ack, err);

endinterface

`default_nettype wire

//--- rtl/pitaya_pkg.sv
// widths, region map, register offsets, bus address union and sample type
`default_nettype none

package pitaya_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////
  localparam int adc_w    = 14;  // ADC and DAC sample width
  localparam int sum_w    = 15;  // sum before saturation
  localparam int bus_w    = 32;  // bus address and data
  localparam int region_w = 3;   // addr 22:20
  localparam int n_region = 8;
  localparam int off_w    = 20;  // offset inside a region
  localparam int led_w    = 8;
  localparam int kp_shift = 12;  // gain is Q1.12 style, shift after multiply

  // region numbers
  localparam logic [region_w-1:0] reg_hk  = 3'd0;  // housekeeping
  localparam logic [region_w-1:0] reg_gen = 3'd2;  // generator, DC level only
  localparam logic [region_w-1:0] reg_pid = 3'd3;  // controller, P term only

  // housekeeping offsets
  localparam logic [off_w-1:0] off_ctrl = 20'h0;  // bit 0 digital loopback
  localparam logic [off_w-1:0] off_led  = 20'h4;
  // per channel offsets, level and gain blocks
  localparam logic [off_w-1:0] off_ch_a = 20'h0;
  localparam logic [off_w-1:0] off_ch_b = 20'h4;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////
  typedef logic signed [adc_w-1:0] sample_t;  // two's complement sample

  // bus address, raw word or split into region and offset
  typedef union packed {
    logic [bus_w-1:0] raw;
    struct packed {
      logic [bus_w-region_w-off_w-1:0] upper;  // ignored by decoding
      logic [region_w-1:0]             region;
      logic [off_w-1:0]                offset;
    } fields;
  } sys_addr_u;

endpackage

`default_nettype wire
